// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module tb_branch_unit -Mdir build
	@out=$$(./build/Vtb_branch_unit); echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf build

// File: design/bju.sv
`timescale 1ns/1ps
`include "bju_params.svh"

module bju
   import rv_isa_pkg::*;
   import bpred_pkg::*;
(
   input  logic               clk,
   input  logic               reset_n,
   input  logic               exec_valid,
   input  logic [31:0]        pc,
   input  logic [31:0]        left_operand,
   input  logic [31:0]        right_operand,
   input  logic [31:0]        immediate_data,
   input  control_type        control,
   input  branch_predict_type branch_predict,
   output logic [31:0]        j_next_pc,
   resolve_if.source          res
);

   logic [31:0] pc_plus_4;
   logic [31:0] pc_plus_imm;
   logic [31:0] rs1_plus_imm;
   logic        rs_eq;
   logic        rs_ltu;
   logic        rs_lt;
   logic        is_bj;
   logic        taken;
   logic [31:0] target_pc;
   logic        dir_wrong;  // predicted direction differs
   logic        addr_wrong; // predicted-taken hit with a bad target

   logic                          ckpt_valid;
   logic [`GSHARE_GHSR_WIDTH-1:0] ckpt;
   logic [`GSHARE_GHSR_WIDTH-1:0] ckpt_base;

   assign pc_plus_4    = pc + 32'd4;
   assign pc_plus_imm  = pc + immediate_data;
   assign rs1_plus_imm = left_operand + immediate_data;
   assign j_next_pc    = pc_plus_4; // link value for jal/jalr

   assign rs_eq  = (left_operand == right_operand);
   assign rs_ltu = (left_operand < right_operand);
   assign rs_lt  = ($signed(left_operand) < $signed(right_operand));

   assign is_bj = control.is_branch || control.is_jump || control.is_jumpr;

   always_comb begin
      taken = 1'b0;
      if (control.is_branch) begin
         case (control.funct3)
            f3_beq:  taken = rs_eq;
            f3_bne:  taken = !rs_eq;
            f3_blt:  taken = rs_lt;
            f3_bge:  taken = !rs_lt;
            f3_bltu: taken = rs_ltu;
            f3_bgeu: taken = !rs_ltu;
            default: taken = 1'b0; // undefined funct3 falls through
         endcase
         target_pc = taken ? pc_plus_imm : pc_plus_4;
      end else if (control.is_jump) begin
         taken     = 1'b1;
         target_pc = pc_plus_imm;
      end else if (control.is_jumpr) begin
         taken     = 1'b1;
         target_pc = {rs1_plus_imm[31:1], 1'b0}; // jalr drops bit 0
      end else begin
         target_pc = pc_plus_4;
      end
   end

   assign dir_wrong  = taken ^ branch_predict.taken;
   assign addr_wrong = branch_predict.btb_hit && branch_predict.taken &&
                       (branch_predict.btb_addr != target_pc);

   assign res.valid        = exec_valid;
   assign res.is_bj        = is_bj;
   assign res.taken        = taken;
   assign res.target_pc    = target_pc;
   assign res.flush        = exec_valid && is_bj && (dir_wrong || addr_wrong);
   assign res.update_ghsr  = exec_valid && is_bj && (!branch_predict.btb_hit || dir_wrong);
   assign res.ghsr_restore = ckpt_valid ? ckpt : branch_predict.current_GHSR;
   assign res.exec_pc      = pc;
   assign res.exec_ghsr    = branch_predict.current_GHSR;

   // first resolution seeds from the fetch history
   assign ckpt_base = ckpt_valid ? ckpt : branch_predict.current_GHSR;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         ckpt_valid <= 1'b0;
         ckpt       <= '0;
      end else if (exec_valid && is_bj) begin
         ckpt_valid <= 1'b1;
         ckpt       <= {ckpt_base[`GSHARE_GHSR_WIDTH-2:0], taken};
      end
   end

   a_funct3_legal: assert property (
      @(posedge clk) disable iff (!reset_n)
      (exec_valid && control.is_branch) |-> funct3_is_legal(control.funct3)
   ) else $error("illegal branch funct3 %b", control.funct3);

   a_ctrl_onehot: assert property (
      @(posedge clk) disable iff (!reset_n)
      exec_valid |-> $onehot0({control.is_branch, control.is_jump, control.is_jumpr})
   ) else $error("more than one branch/jump control bit set");

endmodule

// File: design/bpred_pkg.sv
`include "bju_params.svh"

package bpred_pkg;

   // prediction made at fetch, carried with the instruction to execute
   typedef struct packed {
      logic                          taken;        // pht direction
      logic                          btb_hit;      // tag matched fetch pc
      logic [31:0]                   btb_addr;     // predicted target
      logic [`GSHARE_GHSR_WIDTH-1:0] current_GHSR; // history used for the lookup
   } branch_predict_type;

   // two-bit saturating counter
   typedef enum logic [1:0] {
      strong_nt = 2'b00,
      weak_nt   = 2'b01,
      weak_t    = 2'b10,
      strong_t  = 2'b11
   } counter_state_e;

   function automatic logic counter_taken(counter_state_e c);
      return (c == weak_t) || (c == strong_t);
   endfunction

endpackage

// File: design/branch_unit_top.sv
`timescale 1ns/1ps
`include "bju_params.svh"

module branch_unit_top
   import rv_isa_pkg::*;
   import bpred_pkg::*;
(
   input  logic                                 clk,
   input  logic                                 reset_n,
   input  logic [31:0]                          fetch_pc,
   input  logic                                 fetch_valid,
   input  logic                                 exec_valid,
   input  logic [31:0]                          exec_pc,
   input  logic [31:0]                          left_operand,
   input  logic [31:0]                          right_operand,
   input  logic [31:0]                          immediate_data,
   input  logic [$bits(control_type)-1:0]       exec_control,
   input  logic [$bits(branch_predict_type)-1:0] exec_pred,
   output branch_predict_type                   pred,
   output logic [31:0]                          next_pc,
   output logic                                 flush,
   output logic [31:0]                          j_next_pc
);

   control_type        exec_ctrl_s;
   branch_predict_type exec_pred_s;

   logic                          train_valid;
   logic [31:0]                   train_pc;
   logic                          train_taken;
   logic [31:0]                   train_target;
   logic [`GSHARE_GHSR_WIDTH-1:0] train_ghsr;
   logic                          repair_valid;
   logic [`GSHARE_GHSR_WIDTH-1:0] repair_ghsr;

   resolve_if res_bus ();

   // flat bits back into structs
   assign exec_ctrl_s = control_type'(exec_control);
   assign exec_pred_s = branch_predict_type'(exec_pred);

   gshare_predictor u_gshare (
      .clk          (clk),
      .reset_n      (reset_n),
      .fetch_pc     (fetch_pc),
      .fetch_valid  (fetch_valid),
      .pred         (pred),
      .train_valid  (train_valid),
      .train_pc     (train_pc),
      .train_taken  (train_taken),
      .train_target (train_target),
      .train_ghsr   (train_ghsr),
      .repair_valid (repair_valid),
      .repair_ghsr  (repair_ghsr)
   );

   bju u_bju (
      .clk            (clk),
      .reset_n        (reset_n),
      .exec_valid     (exec_valid),
      .pc             (exec_pc),
      .left_operand   (left_operand),
      .right_operand  (right_operand),
      .immediate_data (immediate_data),
      .control        (exec_ctrl_s),
      .branch_predict (exec_pred_s),
      .j_next_pc      (j_next_pc),
      .res            (res_bus)
   );

   fetch_redirect u_redirect (
      .fetch_pc     (fetch_pc),
      .pred         (pred),
      .res          (res_bus),
      .next_pc      (next_pc),
      .flush        (flush),
      .train_valid  (train_valid),
      .train_pc     (train_pc),
      .train_taken  (train_taken),
      .train_target (train_target),
      .train_ghsr   (train_ghsr),
      .repair_valid (repair_valid),
      .repair_ghsr  (repair_ghsr)
   );

endmodule

// File: design/fetch_redirect.sv
`timescale 1ns/1ps
`include "bju_params.svh"

module fetch_redirect
   import bpred_pkg::*;
(
   input  logic [31:0]                   fetch_pc,
   input  branch_predict_type            pred,
   resolve_if.sink                       res,
   output logic [31:0]                   next_pc,
   output logic                          flush,
   output logic                          train_valid,
   output logic [31:0]                   train_pc,
   output logic                          train_taken,
   output logic [31:0]                   train_target,
   output logic [`GSHARE_GHSR_WIDTH-1:0] train_ghsr,
   output logic                          repair_valid,
   output logic [`GSHARE_GHSR_WIDTH-1:0] repair_ghsr
);

   logic redirect;      // execute overrides fetch
   logic pred_redirect; // btb steers fetch
   logic [31:0] seq_pc;

   assign redirect      = res.valid && res.flush;
   assign pred_redirect = pred.btb_hit && pred.taken;
   assign seq_pc        = fetch_pc + 32'd4;

   // resolution first, then the guess, then fall through
   always_comb begin
      if (redirect) begin
         next_pc = res.target_pc;
      end else if (pred_redirect) begin
         next_pc = pred.btb_addr;
      end else begin
         next_pc = seq_pc;
      end
   end

   assign flush = redirect;

   // only resolved branches and jumps train
   assign train_valid  = res.valid && res.is_bj;
   assign train_pc     = res.exec_pc;
   assign train_taken  = res.taken;
   assign train_target = res.target_pc;
   assign train_ghsr   = res.exec_ghsr; // same history as the original lookup

   assign repair_valid = res.valid && res.update_ghsr;
   assign repair_ghsr  = res.ghsr_restore;

   // the flush from bju must come with its exec strobe
   always_comb begin
      a_flush_needs_valid: assert final (!res.flush || res.valid)
         else $error("resolution flush without valid");
   end

endmodule

// File: design/gshare_predictor.sv
`timescale 1ns/1ps
`include "bju_params.svh"

module gshare_predictor
   import bpred_pkg::*;
(
   input  logic                          clk,
   input  logic                          reset_n,
   input  logic [31:0]                   fetch_pc,
   input  logic                          fetch_valid,
   output branch_predict_type            pred,
   input  logic                          train_valid,
   input  logic [31:0]                   train_pc,
   input  logic                          train_taken,
   input  logic [31:0]                   train_target,
   input  logic [`GSHARE_GHSR_WIDTH-1:0] train_ghsr,
   input  logic                          repair_valid,
   input  logic [`GSHARE_GHSR_WIDTH-1:0] repair_ghsr
);

   counter_state_e                pht [`PHT_DEPTH];
   logic                          btb_valid [`BTB_DEPTH];
   logic [31:0]                   btb_tag [`BTB_DEPTH];
   logic [31:0]                   btb_target [`BTB_DEPTH];
   logic [`GSHARE_GHSR_WIDTH-1:0] ghsr; // speculative history

   logic [`PHT_INDEX_W-1:0] fetch_pht_idx;
   logic [`PHT_INDEX_W-1:0] train_pht_idx;
   logic [`BTB_INDEX_W-1:0] fetch_btb_idx;
   logic [`BTB_INDEX_W-1:0] train_btb_idx;
   logic                    hit;
   logic                    dir_taken;

   function automatic counter_state_e saturate(counter_state_e c, logic t);
      counter_state_e n;
      case (c)
         strong_nt: n = t ? weak_nt  : strong_nt;
         weak_nt:   n = t ? weak_t   : strong_nt;
         weak_t:    n = t ? strong_t : weak_nt;
         default:   n = t ? strong_t : weak_t;
      endcase
      return n;
   endfunction

   // word address bits xor history
   assign fetch_pht_idx = fetch_pc[`PHT_INDEX_W+1:2] ^ `PHT_INDEX_W'(ghsr);
   assign train_pht_idx = train_pc[`PHT_INDEX_W+1:2] ^ `PHT_INDEX_W'(train_ghsr);
   assign fetch_btb_idx = fetch_pc[`BTB_INDEX_W+1:2];
   assign train_btb_idx = train_pc[`BTB_INDEX_W+1:2];

   assign hit       = btb_valid[fetch_btb_idx] && (btb_tag[fetch_btb_idx] == fetch_pc);
   assign dir_taken = counter_taken(pht[fetch_pht_idx]);

   assign pred.taken        = dir_taken;
   assign pred.btb_hit      = hit;
   assign pred.btb_addr     = hit ? btb_target[fetch_btb_idx] : 32'h0; // zero on a miss
   assign pred.current_GHSR = ghsr;

   // history, counters and btb valid bits
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         ghsr <= '0;
         for (int i = 0; i < `PHT_DEPTH; i++) begin
            pht[i] <= weak_nt;
         end
         for (int j = 0; j < `BTB_DEPTH; j++) begin
            btb_valid[j] <= 1'b0;
         end
      end else begin
         if (repair_valid) begin
            ghsr <= repair_ghsr; // repair wins over speculation
         end else if (fetch_valid && hit) begin
            ghsr <= {ghsr[`GSHARE_GHSR_WIDTH-2:0], dir_taken};
         end
         if (train_valid) begin
            pht[train_pht_idx] <= saturate(pht[train_pht_idx], train_taken);
            if (train_taken) begin
               btb_valid[train_btb_idx] <= 1'b1;
            end
         end
      end
   end

   // btb payload
   always_ff @(posedge clk) begin
      if (train_valid && train_taken) begin
         btb_tag[train_btb_idx]    <= train_pc;
         btb_target[train_btb_idx] <= train_target;
      end
   end

   a_ghsr_known: assert property (
      @(posedge clk) disable iff (!reset_n) !$isunknown(ghsr)
   ) else $error("gshare history went unknown");

endmodule

// File: design/resolve_if.sv
`timescale 1ns/1ps
`include "bju_params.svh"

// execute stage resolution, bju to fetch_redirect
interface resolve_if;

   logic                          valid;        // exec strobe
   logic                          is_bj;        // branch or jump in exec
   logic                          taken;        // resolved direction
   logic [31:0]                   target_pc;    // resolved next pc
   logic                          flush;        // misprediction
   logic                          update_ghsr;  // fetch history needs repair
   logic [`GSHARE_GHSR_WIDTH-1:0] ghsr_restore; // value to load on repair
   logic [31:0]                   exec_pc;      // pc of the resolved instr
   logic [`GSHARE_GHSR_WIDTH-1:0] exec_ghsr;    // history seen at its fetch

   modport source (
      output valid, is_bj, taken, target_pc, flush,
      output update_ghsr, ghsr_restore, exec_pc, exec_ghsr
   );

   modport sink (
      input valid, is_bj, taken, target_pc, flush,
      input update_ghsr, ghsr_restore, exec_pc, exec_ghsr
   );

endinterface

// File: design/rv_isa_pkg.sv
package rv_isa_pkg;

   // funct3 field of the rv32i branch opcodes
   typedef enum logic [2:0] {
      f3_beq  = 3'b000,
      f3_bne  = 3'b001,
      f3_blt  = 3'b100,
      f3_bge  = 3'b101,
      f3_bltu = 3'b110,
      f3_bgeu = 3'b111
   } branch_funct3_e;

   // execute stage control, decoded upstream
   typedef struct packed {
      logic           is_branch; // conditional branch
      logic           is_jump;   // jal
      logic           is_jumpr;  // jalr
      branch_funct3_e funct3;
   } control_type;

   // 0, 1, 4..7 are the defined branch encodings
   function automatic logic funct3_is_legal(logic [2:0] f3);
      logic legal;
      legal = (f3 != 3'b010) && (f3 != 3'b011);
      return legal;
   endfunction

endpackage

// File: flist.f
+incdir+include
design/rv_isa_pkg.sv
design/bpred_pkg.sv
design/resolve_if.sv
design/gshare_predictor.sv
design/bju.sv
design/fetch_redirect.sv
design/branch_unit_top.sv
test/tb_branch_unit.sv

// File: include/bju_params.svh
`ifndef BJU_PARAMS_SVH
`define BJU_PARAMS_SVH

// global history length, shared by predictor and execute checkpoint
`define GSHARE_GHSR_WIDTH 8

// pattern table index width, 256 two-bit counters
`define PHT_INDEX_W 8

// btb index width, 16 direct-mapped entries
`define BTB_INDEX_W 4

// derived table depths
`define PHT_DEPTH (1 << `PHT_INDEX_W)
`define BTB_DEPTH (1 << `BTB_INDEX_W)

`endif

// File: test/tb_branch_unit.sv
`timescale 1ns/1ps
`include "bju_params.svh"

module tb_branch_unit
   import rv_isa_pkg::*;
   import bpred_pkg::*;
();

   localparam int cycle_limit = 3000; // stimulus needs about 1050 cycles
   localparam logic [31:0] loop_pc   = 32'h0000_1024; // directed training branch
   localparam logic [31:0] loop_dest = 32'h0000_1064;

   logic        clk, reset_n;
   logic [31:0] fetch_pc;
   logic        fetch_valid, exec_valid;
   logic [31:0] exec_pc, left_operand, right_operand, immediate_data;
   logic [$bits(control_type)-1:0]        exec_control;
   logic [$bits(branch_predict_type)-1:0] exec_pred;
   branch_predict_type pred;
   logic [31:0] next_pc, j_next_pc;
   logic        flush;

   logic        expect_cold;    // lookup right after reset
   logic        expect_trained; // lookup after directed training
   logic [31:0] rng_state;
   int          error_count;
   int          cycle_count;

   // reference model state
   logic [1:0]                    m_pht [`PHT_DEPTH];
   logic                          m_btb_valid [`BTB_DEPTH];
   logic [31:0]                   m_btb_tag [`BTB_DEPTH];
   logic [31:0]                   m_btb_target [`BTB_DEPTH];
   logic [`GSHARE_GHSR_WIDTH-1:0] m_ghsr, m_ckpt, exp_restore;
   logic                          m_ckpt_valid;

   control_type             ctl_s;
   branch_predict_type      ep_s;
   logic [`PHT_INDEX_W-1:0] f_idx, t_idx;
   logic [`BTB_INDEX_W-1:0] fb_idx, tb_idx;
   logic                    r_bj, r_taken, exp_taken, exp_hit, exp_flush, exp_repair;
   logic [31:0]             r_target, exp_addr, exp_next_pc;

   branch_unit_top dut (.*); // port names match one to one

   always #10 clk = ~clk;

   function automatic logic [31:0] xorshift32(logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic logic [31:0] pool_pc(logic [3:0] slot);
      return 32'h0000_1000 + {26'd0, slot, 2'b00}; // one pc per btb entry
   endfunction

   function automatic branch_funct3_e pick_funct3(logic [2:0] sel);
      case (sel)
         3'd0, 3'd6: return f3_beq;
         3'd1, 3'd7: return f3_bne;
         3'd2:       return f3_blt;
         3'd3:       return f3_bge;
         3'd4:       return f3_bltu;
         default:    return f3_bgeu;
      endcase
   endfunction

   // rv32i branch conditions, jumps always taken
   function automatic logic ref_taken(control_type c, logic [31:0] a, logic [31:0] b);
      if (c.is_jump || c.is_jumpr) return 1'b1;
      if (!c.is_branch) return 1'b0;
      case (c.funct3)
         f3_beq:  return a == b;
         f3_bne:  return a != b;
         f3_blt:  return $signed(a) < $signed(b);
         f3_bge:  return $signed(a) >= $signed(b);
         f3_bltu: return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic logic [31:0] ref_target(control_type c, logic t, logic [31:0] pc,
                                              logic [31:0] a, logic [31:0] imm);
      if (c.is_jumpr) return (a + imm) & 32'hffff_fffe;
      if (c.is_jump || t) return pc + imm;
      return pc + 32'd4;
   endfunction

   function automatic logic [1:0] bump(logic [1:0] c, logic t);
      if (t) return (c == 2'd3) ? c : c + 2'd1;
      return (c == 2'd0) ? c : c - 2'd1;
   endfunction

   always_comb begin
      ctl_s       = control_type'(exec_control);
      ep_s        = branch_predict_type'(exec_pred);
      f_idx       = fetch_pc[`PHT_INDEX_W+1:2] ^ m_ghsr;
      fb_idx      = fetch_pc[`BTB_INDEX_W+1:2];
      t_idx       = exec_pc[`PHT_INDEX_W+1:2] ^ ep_s.current_GHSR;
      tb_idx      = exec_pc[`BTB_INDEX_W+1:2];
      exp_taken   = m_pht[f_idx] >= 2'd2; // weak or strong taken
      exp_hit     = m_btb_valid[fb_idx] && (m_btb_tag[fb_idx] == fetch_pc);
      exp_addr    = m_btb_target[fb_idx];
      r_bj        = ctl_s.is_branch || ctl_s.is_jump || ctl_s.is_jumpr;
      r_taken     = ref_taken(ctl_s, left_operand, right_operand);
      r_target    = ref_target(ctl_s, r_taken, exec_pc, left_operand, immediate_data);
      exp_flush   = exec_valid && r_bj && ((r_taken != ep_s.taken) ||
                    (ep_s.btb_hit && ep_s.taken && (ep_s.btb_addr != r_target)));
      exp_repair  = exec_valid && r_bj && (!ep_s.btb_hit || (r_taken != ep_s.taken));
      exp_restore = m_ckpt_valid ? m_ckpt : ep_s.current_GHSR;
      if (exp_flush) begin
         exp_next_pc = r_target;
      end else if (exp_hit && exp_taken) begin
         exp_next_pc = exp_addr;
      end else begin
         exp_next_pc = fetch_pc + 32'd4;
      end
   end

   always @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < `PHT_DEPTH; i++) begin
            m_pht[i] <= 2'b01; // weakly not taken
         end
         for (int i = 0; i < `BTB_DEPTH; i++) begin
            m_btb_valid[i] <= 1'b0;
         end
         m_ghsr       <= '0;
         m_ckpt_valid <= 1'b0;
         m_ckpt       <= '0;
      end else begin
         if (exp_repair) begin
            m_ghsr <= exp_restore;
         end else if (fetch_valid && exp_hit) begin
            m_ghsr <= {m_ghsr[`GSHARE_GHSR_WIDTH-2:0], exp_taken};
         end
         if (exec_valid && r_bj) begin
            m_pht[t_idx] <= bump(m_pht[t_idx], r_taken);
            m_ckpt_valid <= 1'b1;
            m_ckpt       <= {exp_restore[`GSHARE_GHSR_WIDTH-2:0], r_taken};
            if (r_taken) begin
               m_btb_valid[tb_idx]  <= 1'b1;
               m_btb_tag[tb_idx]    <= exec_pc;
               m_btb_target[tb_idx] <= r_target;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout, run went past %0d cycles", cycle_limit);
         $display("Some tests failed");
         $finish;
      end
   end

   task automatic report_mismatch(string name, logic [31:0] expv, logic [31:0] got);
      error_count++;
      $display("CHECK FAILED %s expected %h got %h", name, expv, got);
   endtask

   task automatic report_failure(string what);
      error_count++;
      $display("%s", what);
   endtask

   a_taken: assert property (@(posedge clk) disable iff (!reset_n) pred.taken == exp_taken)
      else report_mismatch("pred.taken", 32'($sampled(exp_taken)), 32'($sampled(pred.taken)));
   a_hit: assert property (@(posedge clk) disable iff (!reset_n) pred.btb_hit == exp_hit)
      else report_mismatch("pred.btb_hit", 32'($sampled(exp_hit)), 32'($sampled(pred.btb_hit)));
   a_addr: assert property (@(posedge clk) disable iff (!reset_n)
      exp_hit |-> pred.btb_addr == exp_addr)
      else report_mismatch("pred.btb_addr", $sampled(exp_addr), $sampled(pred.btb_addr));
   a_ghsr: assert property (@(posedge clk) disable iff (!reset_n) pred.current_GHSR == m_ghsr)
      else report_mismatch("pred.current_GHSR", 32'($sampled(m_ghsr)),
                           32'($sampled(pred.current_GHSR)));
   a_next_pc: assert property (@(posedge clk) disable iff (!reset_n) next_pc == exp_next_pc)
      else report_mismatch("next_pc", $sampled(exp_next_pc), $sampled(next_pc));
   a_flush: assert property (@(posedge clk) disable iff (!reset_n) flush == exp_flush)
      else report_mismatch("flush", 32'($sampled(exp_flush)), 32'($sampled(flush)));
   a_link: assert property (@(posedge clk) disable iff (!reset_n) j_next_pc == exec_pc + 32'd4)
      else report_mismatch("j_next_pc", $sampled(exec_pc) + 32'd4, $sampled(j_next_pc));
   a_cold: assert property (@(posedge clk) disable iff (!reset_n)
      expect_cold |-> !pred.btb_hit && !pred.taken)
      else report_failure("lookup right after reset hit the btb or predicted taken");
   a_trained: assert property (@(posedge clk) disable iff (!reset_n)
      expect_trained |-> pred.btb_hit && pred.taken && pred.btb_addr == loop_dest)
      else report_failure("trained branch was not predicted taken to its target");

   // random prediction, right target on about half of them
   task automatic send_exec(control_type c, logic [31:0] pc, logic [31:0] a,
                            logic [31:0] b, logic [31:0] imm);
      logic [31:0]        r;
      branch_predict_type p;
      r              = next_rand();
      p.taken        = r[0];
      p.btb_hit      = r[1];
      p.btb_addr     = r[2] ? ref_target(c, ref_taken(c, a, b), pc, a, imm) : next_rand();
      p.current_GHSR = r[15:8];
      exec_valid     <= 1'b1;
      exec_control   <= c;
      exec_pc        <= pc;
      left_operand   <= a;
      right_operand  <= b;
      immediate_data <= imm;
      exec_pred      <= p;
   endtask

   // kind 0 branch, 1 jal, 2 jalr, 3 plain instruction
   task automatic send_random_bj(logic [1:0] kind);
      logic [31:0] r;
      logic [31:0] a;
      control_type c;
      r           = next_rand();
      a           = next_rand();
      c           = '0;
      c.is_branch = (kind == 2'd0);
      c.is_jump   = (kind == 2'd1);
      c.is_jumpr  = (kind == 2'd2);
      c.funct3    = pick_funct3(r[2:0]);
      send_exec(c, pool_pc(r[7:4]), a, r[3] ? a : next_rand(), {{19{r[31]}}, r[31:20], 1'b0});
   endtask

   task automatic send_fetch();
      logic [31:0] r;
      r = next_rand();
      fetch_valid <= r[0];
      fetch_pc    <= pool_pc(r[4:1]);
   endtask

   // beq with equal operands, always taken to loop_dest
   task automatic send_loop_branch(branch_predict_type p);
      control_type c;
      c           = '0;
      c.is_branch = 1'b1;
      c.funct3    = f3_beq;
      exec_valid     <= 1'b1;
      exec_control   <= c;
      exec_pc        <= loop_pc;
      left_operand   <= 32'h0000_00aa;
      right_operand  <= 32'h0000_00aa;
      immediate_data <= loop_dest - loop_pc;
      exec_pred      <= p;
   endtask

   initial begin
      logic [31:0]        r;
      branch_predict_type seen;
      clk = 1'b0;
      reset_n = 1'b0;
      fetch_pc = '0;
      fetch_valid = 1'b0;
      exec_valid = 1'b0;
      exec_pc = '0;
      left_operand = '0;
      right_operand = '0;
      immediate_data = '0;
      exec_control = '0;
      exec_pred = '0;
      expect_cold = 1'b0;
      expect_trained = 1'b0;
      rng_state = 32'ha1e5;
      error_count = 0;
      cycle_count = 0;
      repeat (4) @(posedge clk);
      reset_n <= 1'b1;
      repeat (400) begin // conditional branches
         @(posedge clk);
         send_fetch();
         send_random_bj(2'd0);
      end
      repeat (200) begin // jal and jalr
         @(posedge clk);
         send_fetch();
         send_random_bj(rng_state[7] ? 2'd1 : 2'd2);
      end
      @(posedge clk);
      reset_n     <= 1'b0;
      exec_valid  <= 1'b0;
      fetch_valid <= 1'b0;
      repeat (4) @(posedge clk);
      reset_n     <= 1'b1;
      fetch_pc    <= loop_pc;
      expect_cold <= 1'b1;
      // history fed back from the lookup, as fetch would carry it
      repeat (4) begin
         @(negedge clk);
         seen = pred;
         @(posedge clk);
         expect_cold <= 1'b0;
         send_loop_branch(seen);
         @(posedge clk);
         exec_valid <= 1'b0; // training lands before the next lookup
      end
      @(posedge clk);
      expect_trained <= 1'b1;
      repeat (400) begin // mixed traffic with idle execute cycles
         @(posedge clk);
         expect_trained <= 1'b0;
         send_fetch();
         r = next_rand();
         if (r[0]) begin
            exec_valid <= 1'b0;
         end else begin
            send_random_bj(r[2:1]);
         end
      end
      @(posedge clk);
      exec_valid  <= 1'b0;
      fetch_valid <= 1'b0;
      repeat (2) @(posedge clk);
      $display("errors: %0d, cycles run: %0d", error_count, cycle_count);
      if (error_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule
